// ==== include/pcxt_config.svh ====
////////////////////
// default timing constants for the board glue
// audio enable step and modulus, accumulator width
// phantom column count and colour depth
////////////////////

`ifndef PCXT_CONFIG_SVH
`define PCXT_CONFIG_SVH

// 44.1 kHz enable from the 50 MHz clock
`define PCXT_AUDIO_STEP 44100
`define PCXT_AUDIO_MOD 50000000
`define PCXT_ACC_W 32

// splash timer, one second of CLK_50M per tick period
`define PCXT_SPLASH_TICKS 50000000
`define PCXT_SPLASH_SECONDS 5

// system reset stretch after the last request
`define PCXT_SYS_RESET_CYCLES 65535
// extra hold on the cpu reset
`define PCXT_CPU_RESET_DELAY 42

// tandy graphics ghost column
// 48 hides the ghost line, 47 leaves it visible
`define PCXT_BLANK_COLUMNS 48

// bits per colour channel on the vga side
`define PCXT_RGB_W 6

`endif

// ==== verilog/pcxt_board_pkg.sv ====
////////////////////
// board side types
// menu status bits and ps/2 keyboard lines
////////////////////

package pcxt_board_pkg;

	// menu status bits coming from the osd side
	// all four are levels, asynchronous to CLK_50M
	typedef struct packed {
		// menu reset item
		logic reset_req;
		// bios rom download running
		logic bios_load;
		// tandy 1000 model selected
		logic tandy_mode;
		// splash screen turned off
		logic splash_skip;
	} menu_status_t;

	// ps/2 keyboard port, clock and data
	typedef struct packed {
		logic clk;
		logic data;
	} ps2_lines_t;

endpackage

// ==== verilog/pcxt_video_pkg.sv ====
////////////////////
// video types
// rgb pixel and video input bundle
////////////////////

`include "pcxt_config.svh"

package pcxt_video_pkg;

	// one pixel, all zero is black
	typedef struct packed {
		logic [`PCXT_RGB_W-1:0] r;
		logic [`PCXT_RGB_W-1:0] g;
		logic [`PCXT_RGB_W-1:0] b;
	} vga_pixel_t;

	// video stream from the cga/tandy side
	// synchronous to CLK_50M, qualified by the pixel strobe
	typedef struct packed {
		vga_pixel_t pixel;
		// active high line sync
		logic       hsync;
		// graphics mode, text when low
		logic       grph_mode;
	} video_in_t;

endpackage

// ==== verilog/sync_stage.sv ====
////////////////////
// two-flop synchronizer
// payload type set by parameter
////////////////////

module sync_stage #(
	parameter type payload_t = logic
) (
	input  logic     CLK_50M,
	input  logic     reset_wire,
	input  payload_t d_i,
	output payload_t q_o
);

	// first stage, may go metastable
	payload_t meta_q;

	always_ff @(posedge CLK_50M or posedge reset_wire) begin
		if (reset_wire) begin
			meta_q <= '0;
			q_o    <= '0;
		end else begin
			meta_q <= d_i;
			// second stage, settled value
			q_o    <= meta_q;
		end
	end

endmodule

// ==== verilog/audio_cen_gen.sv ====
////////////////////
// 44.1 kHz clock enable
// fractional accumulator on CLK_50M
////////////////////

`include "pcxt_config.svh"

module audio_cen_gen (
	input  logic CLK_50M,
	input  logic reset_wire,
	output logic audio_cen_o
);

	// step over modulus gives the sample rate ratio
	localparam logic [`PCXT_ACC_W-1:0] STEP = `PCXT_AUDIO_STEP;
	localparam logic [`PCXT_ACC_W-1:0] MOD  = `PCXT_AUDIO_MOD;

	logic [`PCXT_ACC_W-1:0] acc_q;
	logic [`PCXT_ACC_W-1:0] acc_sum;

	// next phase before the wrap
	assign acc_sum = acc_q + STEP;

	always_ff @(posedge CLK_50M or posedge reset_wire) begin
		if (reset_wire) begin
			acc_q       <= '0;
			audio_cen_o <= 1'b0;
		end else if (acc_sum >= MOD) begin
			// wrap, keep the remainder so no fraction is lost
			acc_q       <= acc_sum - MOD;
			audio_cen_o <= 1'b1;
		end else begin
			acc_q       <= acc_sum;
			audio_cen_o <= 1'b0;
		end
	end

endmodule

// ==== verilog/reset_sequencer.sv ====
////////////////////
// splash screen timer
// system reset stretcher
// cpu reset release delay
////////////////////

`include "pcxt_config.svh"

module reset_sequencer #(
	parameter int unsigned SPLASH_TICKS     = `PCXT_SPLASH_TICKS,
	parameter int unsigned SPLASH_SECONDS   = `PCXT_SPLASH_SECONDS,
	parameter int unsigned SYS_RESET_CYCLES = `PCXT_SYS_RESET_CYCLES,
	parameter int unsigned CPU_RESET_DELAY  = `PCXT_CPU_RESET_DELAY
) (
	input  logic                         CLK_50M,
	input  logic                         reset_wire,
	input  pcxt_board_pkg::menu_status_t menu_i,
	output logic                         sys_reset_o,
	output logic                         cpu_reset_o
);

	// counter widths
	localparam int TICK_W    = (SPLASH_TICKS > 1) ? $clog2(SPLASH_TICKS) : 1;
	localparam int SEC_W     = $clog2(SPLASH_SECONDS + 1);
	localparam int STRETCH_W = $clog2(SYS_RESET_CYCLES + 1);
	localparam int CPU_W     = $clog2(CPU_RESET_DELAY + 1);

	// terminal counts
	localparam logic [TICK_W-1:0]    TICK_LAST    = TICK_W'(SPLASH_TICKS - 1);
	localparam logic [SEC_W-1:0]     SEC_END      = SEC_W'(SPLASH_SECONDS);
	localparam logic [STRETCH_W-1:0] STRETCH_END  = STRETCH_W'(SYS_RESET_CYCLES);
	localparam logic [STRETCH_W-1:0] STRETCH_LAST = STRETCH_W'(SYS_RESET_CYCLES - 1);
	localparam logic [CPU_W-1:0]     CPU_END      = CPU_W'(CPU_RESET_DELAY);
	localparam logic [CPU_W-1:0]     CPU_LAST     = CPU_W'(CPU_RESET_DELAY - 1);

	logic                 splash_q;
	logic [TICK_W-1:0]    tick_cnt_q;
	logic [SEC_W-1:0]     sec_cnt_q;
	logic [STRETCH_W-1:0] stretch_cnt_q;
	logic [CPU_W-1:0]     cpu_cnt_q;
	logic                 splash_on;
	logic                 hold_req;

	// skip takes effect at once, the register follows a cycle later
	assign splash_on = splash_q & ~menu_i.splash_skip;
	// anything that keeps the board in reset
	assign hold_req  = splash_on | menu_i.reset_req | menu_i.bios_load;

	////////////////////
	// splash timer
	////////////////////

	// runs once per reset_wire, a menu reset does not restart it
	always_ff @(posedge CLK_50M or posedge reset_wire) begin
		if (reset_wire) begin
			splash_q   <= 1'b1;
			tick_cnt_q <= '0;
			sec_cnt_q  <= '0;
		end else if (splash_q) begin
			if (menu_i.splash_skip || sec_cnt_q == SEC_END) begin
				splash_q <= 1'b0;
			end else if (tick_cnt_q == TICK_LAST) begin
				// one second done
				tick_cnt_q <= '0;
				sec_cnt_q  <= sec_cnt_q + 1'b1;
			end else begin
				tick_cnt_q <= tick_cnt_q + 1'b1;
			end
		end
	end

	////////////////////
	// reset stretch
	////////////////////

	// counter held at zero while any request is up
	always_ff @(posedge CLK_50M or posedge reset_wire) begin
		if (reset_wire) begin
			stretch_cnt_q <= '0;
			sys_reset_o   <= 1'b1;
		end else if (hold_req) begin
			stretch_cnt_q <= '0;
			sys_reset_o   <= 1'b1;
		end else if (stretch_cnt_q != STRETCH_END) begin
			stretch_cnt_q <= stretch_cnt_q + 1'b1;
			// release on the edge that reaches the end count
			sys_reset_o   <= (stretch_cnt_q != STRETCH_LAST);
		end
	end

	// cpu comes out a fixed delay after the system
	// a new request sets it together with sys_reset_o
	always_ff @(posedge CLK_50M or posedge reset_wire) begin
		if (reset_wire) begin
			cpu_cnt_q   <= '0;
			cpu_reset_o <= 1'b1;
		end else if (sys_reset_o || hold_req) begin
			cpu_cnt_q   <= '0;
			cpu_reset_o <= 1'b1;
		end else if (cpu_cnt_q != CPU_END) begin
			cpu_cnt_q   <= cpu_cnt_q + 1'b1;
			cpu_reset_o <= (cpu_cnt_q != CPU_LAST);
		end
	end

endmodule

// ==== verilog/phantom_column_mask.sv ====
////////////////////
// tandy phantom column mask
// blanks the first columns of each line
////////////////////

`include "pcxt_config.svh"

module phantom_column_mask (
	input  logic                       CLK_50M,
	input  logic                       reset_wire,
	input  logic                       pix_ce_i,
	input  logic                       tandy_mode_i,
	input  pcxt_video_pkg::video_in_t  video_i,
	output pcxt_video_pkg::vga_pixel_t video_o
);

	import pcxt_video_pkg::*;

	localparam int COL_W = $clog2(`PCXT_BLANK_COLUMNS + 1);
	localparam logic [COL_W-1:0] COL_END = COL_W'(`PCXT_BLANK_COLUMNS);

	// strobes seen since the last hsync
	logic [COL_W-1:0] col_cnt_q;
	// delayed pixel, black inside the blanked area
	vga_pixel_t       held_q;
	logic             mask_on;

	////////////////////
	// column counter
	////////////////////

	always_ff @(posedge CLK_50M or posedge reset_wire) begin
		if (reset_wire) begin
			col_cnt_q <= '0;
			held_q    <= '0;
		end else if (video_i.hsync) begin
			// new line, restart the count
			col_cnt_q <= '0;
		end else if (pix_ce_i) begin
			if (col_cnt_q < COL_END) begin
				col_cnt_q <= col_cnt_q + 1'b1;
				held_q    <= '0;
			end else begin
				held_q <= video_i.pixel;
			end
		end
	end

	// only tandy graphics shows the ghost column
	assign mask_on = tandy_mode_i & video_i.grph_mode;

	// text modes and other models pass straight through
	assign video_o = mask_on ? held_q : video_i.pixel;

endmodule

// ==== verilog/pcxt_glue_top.sv ====
////////////////////
// pc/xt board glue top level
// input synchronizers, audio enable
// reset sequencing, tandy column mask
////////////////////

`include "pcxt_config.svh"

module pcxt_glue_top #(
	parameter int unsigned SPLASH_TICKS     = `PCXT_SPLASH_TICKS,
	parameter int unsigned SPLASH_SECONDS   = `PCXT_SPLASH_SECONDS,
	parameter int unsigned SYS_RESET_CYCLES = `PCXT_SYS_RESET_CYCLES,
	parameter int unsigned CPU_RESET_DELAY  = `PCXT_CPU_RESET_DELAY
) (
	input  logic                         CLK_50M,
	input  logic                         reset_wire,
	input  pcxt_board_pkg::menu_status_t menu_i,
	input  pcxt_board_pkg::ps2_lines_t   ps2_i,
	input  pcxt_video_pkg::video_in_t    video_i,
	input  logic                         pix_ce_i,
	output pcxt_board_pkg::ps2_lines_t   ps2_o,
	output logic                         audio_cen_o,
	output logic                         sys_reset_o,
	output logic                         cpu_reset_o,
	output pcxt_video_pkg::vga_pixel_t   video_o
);

	import pcxt_board_pkg::*;

	// menu bits in the CLK_50M domain
	menu_status_t menu_sync;

	////////////////////
	// synchronizers
	////////////////////

	sync_stage #(
		.payload_t(menu_status_t)
	) menu_sync_stage (
		.CLK_50M   (CLK_50M),
		.reset_wire(reset_wire),
		.d_i       (menu_i),
		.q_o       (menu_sync)
	);

	// keyboard lines go out to the controller as they are
	sync_stage #(
		.payload_t(ps2_lines_t)
	) ps2_sync_stage (
		.CLK_50M   (CLK_50M),
		.reset_wire(reset_wire),
		.d_i       (ps2_i),
		.q_o       (ps2_o)
	);

	// audio sample enable
	audio_cen_gen u_audio_cen_gen (
		.CLK_50M    (CLK_50M),
		.reset_wire (reset_wire),
		.audio_cen_o(audio_cen_o)
	);

	// splash, system and cpu reset
	reset_sequencer #(
		.SPLASH_TICKS    (SPLASH_TICKS),
		.SPLASH_SECONDS  (SPLASH_SECONDS),
		.SYS_RESET_CYCLES(SYS_RESET_CYCLES),
		.CPU_RESET_DELAY (CPU_RESET_DELAY)
	) u_reset_sequencer (
		.CLK_50M    (CLK_50M),
		.reset_wire (reset_wire),
		.menu_i     (menu_sync),
		.sys_reset_o(sys_reset_o),
		.cpu_reset_o(cpu_reset_o)
	);

	// video output path
	phantom_column_mask u_phantom_column_mask (
		.CLK_50M     (CLK_50M),
		.reset_wire  (reset_wire),
		.pix_ce_i    (pix_ce_i),
		.tandy_mode_i(menu_sync.tandy_mode),
		.video_i     (video_i),
		.video_o     (video_o)
	);

endmodule

// ==== tb/pcxt_glue_tb.sv ====
////////////////////
// directed testbench for the board glue top level
// clock, reset, compare tasks and the six tests
////////////////////

`include "pcxt_config.svh"

module pcxt_glue_tb;

	timeunit 1ns;
	timeprecision 100ps;

	import pcxt_board_pkg::*;
	import pcxt_video_pkg::*;

	// shrunk timing so the splash fits in a short run
	localparam int SPLASH_TICKS     = 20;
	localparam int SPLASH_SECONDS   = 5;
	localparam int SYS_RESET_CYCLES = 16;
	localparam int CPU_RESET_DELAY  = 4;
	localparam int AUDIO_CYCLES     = 100000;
	localparam int PIXEL_COUNT      = 60;
	// synchronizer plus register delay on a menu change
	localparam int SYNC_SLACK       = 3;

	logic         CLK_50M;
	logic         reset_wire;
	menu_status_t menu_i;
	ps2_lines_t   ps2_i;
	ps2_lines_t   ps2_o;
	video_in_t    video_i;
	logic         pix_ce_i;
	logic         audio_cen_o;
	logic         sys_reset_o;
	logic         cpu_reset_o;
	vga_pixel_t   video_o;
	integer       seed;

	pcxt_glue_top #(
		.SPLASH_TICKS    (SPLASH_TICKS),
		.SPLASH_SECONDS  (SPLASH_SECONDS),
		.SYS_RESET_CYCLES(SYS_RESET_CYCLES),
		.CPU_RESET_DELAY (CPU_RESET_DELAY)
	) DUT (
		.CLK_50M    (CLK_50M),
		.reset_wire (reset_wire),
		.menu_i     (menu_i),
		.ps2_i      (ps2_i),
		.video_i    (video_i),
		.pix_ce_i   (pix_ce_i),
		.ps2_o      (ps2_o),
		.audio_cen_o(audio_cen_o),
		.sys_reset_o(sys_reset_o),
		.cpu_reset_o(cpu_reset_o),
		.video_o    (video_o)
	);

	// 50 MHz
	initial begin
		CLK_50M = 1'b0;
		forever #10 CLK_50M = ~CLK_50M;
	end

	////////////////////
	// compare tasks
	////////////////////

	task automatic abort_run(input string msg);
		$display("%s", msg);
		$display("Test failed");
		$fatal(1);
	endtask

	task automatic check_bit(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			abort_run($sformatf("error %s expected %b actual %b", name, exp, act));
		end
	endtask

	task automatic check_count(input string name, input int exp, input int act);
		if (act != exp) begin
			abort_run($sformatf("error %s expected %0d actual %0d", name, exp, act));
		end
	endtask

	task automatic check_pixel(input string name, input vga_pixel_t exp, input vga_pixel_t act);
		if (act !== exp) begin
			abort_run($sformatf("error %s expected %h actual %h", name, exp, act));
		end
	endtask

	////////////////////
	// helpers
	////////////////////

	function automatic vga_pixel_t random_pixel();
		logic [31:0] rnd;
		rnd = $random(seed);
		return rnd[$bits(vga_pixel_t)-1:0];
	endfunction

	// two cycles of reset, menu settles meanwhile
	task automatic apply_reset(input menu_status_t menu);
		@(negedge CLK_50M);
		reset_wire = 1'b1;
		menu_i     = menu;
		video_i    = '0;
		pix_ce_i   = 1'b0;
		repeat (2) @(negedge CLK_50M);
		reset_wire = 1'b0;
	endtask

	// sys reset held for hold_cycles, low by limit, cpu follows exactly
	task automatic wait_release(input string name, input int hold_cycles, input int limit);
		int cycle;
		bit released;
		for (cycle = 1; cycle <= hold_cycles; cycle++) begin
			@(negedge CLK_50M);
			check_bit(name, 1'b1, sys_reset_o);
		end
		released = 1'b0;
		cycle    = hold_cycles;
		while (!released && cycle < limit) begin
			@(negedge CLK_50M);
			cycle++;
			released = !sys_reset_o;
		end
		if (!released) begin
			abort_run($sformatf("%s: system reset not released within %0d cycles", name, limit));
		end
		check_bit(name, 1'b1, cpu_reset_o);
		for (int k = 1; k <= CPU_RESET_DELAY; k++) begin
			@(negedge CLK_50M);
			check_bit(name, (k < CPU_RESET_DELAY), cpu_reset_o);
		end
	endtask

	// new request must pull both resets back up
	task automatic raise_request(input string name, input menu_status_t menu);
		int cycle;
		bit raised;
		@(negedge CLK_50M);
		menu_i = menu;
		raised = 1'b0;
		cycle  = 0;
		while (!raised && cycle < SYNC_SLACK) begin
			@(negedge CLK_50M);
			cycle++;
			raised = sys_reset_o;
		end
		if (!raised) begin
			abort_run($sformatf("%s: system reset did not rise after a request", name));
		end
		check_bit(name, 1'b1, cpu_reset_o);
	endtask

	////////////////////
	// tests
	////////////////////

	task automatic test_audio_cen();
		int pulses;
		int expected;
		apply_reset('0);
		pulses = 0;
		repeat (AUDIO_CYCLES) begin
			@(negedge CLK_50M);
			if (audio_cen_o) begin
				pulses++;
			end
		end
		// floor of cycles times step over modulus
		expected = int'((longint'(AUDIO_CYCLES) * `PCXT_AUDIO_STEP) / `PCXT_AUDIO_MOD);
		check_count("test_audio_cen", expected, pulses);
	endtask

	task automatic test_splash_hold();
		int splash_len;
		splash_len = SPLASH_TICKS * SPLASH_SECONDS;
		apply_reset('0);
		wait_release("test_splash_hold", splash_len,
			splash_len + SYS_RESET_CYCLES + SYNC_SLACK);
	endtask

	task automatic test_skip_and_request();
		menu_status_t menu;
		menu             = '0;
		menu.splash_skip = 1'b1;
		apply_reset(menu);
		wait_release("test_skip_and_request", SYS_RESET_CYCLES - 1, SYS_RESET_CYCLES + SYNC_SLACK);
		// menu reset item
		menu.reset_req = 1'b1;
		raise_request("test_skip_and_request", menu);
		menu.reset_req = 1'b0;
		@(negedge CLK_50M);
		menu_i = menu;
		wait_release("test_skip_and_request", SYS_RESET_CYCLES - 1, SYS_RESET_CYCLES + SYNC_SLACK);
		// bios download
		menu.bios_load = 1'b1;
		raise_request("test_skip_and_request", menu);
		menu.bios_load = 1'b0;
		@(negedge CLK_50M);
		menu_i = menu;
		wait_release("test_skip_and_request", SYS_RESET_CYCLES - 1, SYS_RESET_CYCLES + SYNC_SLACK);
	endtask

	task automatic test_phantom_mask();
		vga_pixel_t   pix [PIXEL_COUNT];
		vga_pixel_t   expected;
		menu_status_t menu;
		menu             = '0;
		menu.splash_skip = 1'b1;
		menu.tandy_mode  = 1'b1;
		for (int k = 0; k < PIXEL_COUNT; k++) begin
			pix[k] = random_pixel();
		end
		@(negedge CLK_50M);
		menu_i = menu;
		// strobes before the line start leave the counter mid-line
		video_i.hsync = 1'b0;
		pix_ce_i      = 1'b1;
		// tandy bit through the synchronizer
		repeat (SYNC_SLACK) @(negedge CLK_50M);
		// strobe stays on, hsync has to win
		video_i.hsync     = 1'b1;
		video_i.grph_mode = 1'b1;
		@(negedge CLK_50M);
		video_i.hsync = 1'b0;
		video_i.pixel = pix[0];
		pix_ce_i      = 1'b1;
		for (int k = 0; k < PIXEL_COUNT; k++) begin
			@(negedge CLK_50M);
			// leading columns black, then one strobe behind
			if (k < `PCXT_BLANK_COLUMNS) begin
				expected = '0;
			end else begin
				expected = pix[k];
			end
			check_pixel("test_phantom_mask", expected, video_o);
			if (k + 1 < PIXEL_COUNT) begin
				video_i.pixel = pix[k + 1];
			end else begin
				pix_ce_i = 1'b0;
			end
		end
	endtask

	task automatic check_passthrough(input string name, input logic tandy, input logic grph);
		menu_status_t menu;
		vga_pixel_t   pix;
		menu             = '0;
		menu.splash_skip = 1'b1;
		menu.tandy_mode  = tandy;
		@(negedge CLK_50M);
		menu_i            = menu;
		video_i.hsync     = 1'b0;
		video_i.grph_mode = grph;
		pix_ce_i          = 1'b1;
		repeat (SYNC_SLACK) @(negedge CLK_50M);
		for (int k = 0; k < 8; k++) begin
			pix           = random_pixel();
			video_i.pixel = pix;
			// combinational path, sampled before the next rising edge
			#5;
			check_pixel(name, pix, video_o);
			@(negedge CLK_50M);
		end
		pix_ce_i = 1'b0;
	endtask

	task automatic test_passthrough();
		// non tandy model in graphics
		check_passthrough("test_passthrough", 1'b0, 1'b1);
		// tandy in text mode
		check_passthrough("test_passthrough", 1'b1, 1'b0);
	endtask

	task automatic test_ps2_sync();
		logic [1:0] values [5];
		int         cycle;
		bit         seen;
		values = '{2'b01, 2'b10, 2'b11, 2'b00, 2'b10};
		for (int n = 0; n < 5; n++) begin
			@(negedge CLK_50M);
			ps2_i = values[n];
			seen  = 1'b0;
			cycle = 0;
			while (!seen && cycle < SYNC_SLACK) begin
				@(negedge CLK_50M);
				cycle++;
				seen = (ps2_o == ps2_i);
			end
			if (!seen) begin
				abort_run("test_ps2_sync: keyboard lines did not reach the output in time");
			end
			// value must hold
			repeat (3) begin
				@(negedge CLK_50M);
				check_bit("test_ps2_sync", ps2_i.clk, ps2_o.clk);
				check_bit("test_ps2_sync", ps2_i.data, ps2_o.data);
			end
		end
	endtask

	////////////////////
	// main sequence
	////////////////////

	initial begin
		seed       = 32'h7e3b;
		reset_wire = 1'b1;
		menu_i     = '0;
		ps2_i      = '0;
		video_i    = '0;
		pix_ce_i   = 1'b0;
		test_audio_cen();
		test_splash_hold();
		test_skip_and_request();
		test_phantom_mask();
		test_passthrough();
		test_ps2_sync();
		$display("Test passed");
		$finish;
	end

endmodule

// ==== vlog.f ====
+incdir+include
verilog/pcxt_board_pkg.sv
verilog/pcxt_video_pkg.sv
verilog/sync_stage.sv
verilog/audio_cen_gen.sv
verilog/reset_sequencer.sv
verilog/phantom_column_mask.sv
verilog/pcxt_glue_top.sv
tb/pcxt_glue_tb.sv

// ==== Bender.yml ====
package:
  name: pcxt_glue

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - verilog/pcxt_board_pkg.sv
      - verilog/pcxt_video_pkg.sv
      - verilog/sync_stage.sv
      - verilog/audio_cen_gen.sv
      - verilog/reset_sequencer.sv
      - verilog/phantom_column_mask.sv
      - verilog/pcxt_glue_top.sv

  - target: simulation
    include_dirs:
      - include
    files:
      - tb/pcxt_glue_tb.sv
